//--- design/dcache_pkg.sv
/*
  Shared types for the data cache and its testbench.
  Field widths fix the geometry: 26-bit tag, 3-bit index, 1-bit block offset,
  2-bit byte offset. The cache parameters must agree with these widths.
*/
`default_nettype none

package dcache_pkg;

  // Data word or byte address
  typedef logic [31:0] word_t;

  // Block tag, upper address bits
  typedef logic [25:0] tag_t;

  // Set index, sits above the block offset
  typedef logic [2:0] index_t;

  // MSI line state
  typedef enum logic [1:0] {
    invalid  = 2'b00,
    shared   = 2'b01,
    modified = 2'b10
  } line_state_t;

  // Controller states
  typedef enum logic [3:0] {
    idle         = 4'd0,
    writeback0   = 4'd1,
    writeback1   = 4'd2,
    fetch0       = 4'd3,
    fetch1       = 4'd4,
    snoop        = 4'd5,
    snoop_flush0 = 4'd6,
    snoop_flush1 = 4'd7
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/dcache_lookup.sv
/*
  Tag, MSI state and LRU storage for the data cache.
  num_sets must equal 2**index width; the LRU bit assumes two ways.
  States and LRU bits clear on reset, tags are left as they are.
*/
`timescale 1ns/10ps
`default_nettype none

module dcache_lookup #(
  parameter int num_sets        = 8,
  parameter int num_ways        = 2,
  parameter int words_per_block = 2
) (
  input  logic                     CLK,
  input  logic                     reset,
  input  dcache_pkg::word_t        dmem_addr,
  input  dcache_pkg::word_t        cc_snoop_addr,
  input  logic                     install,
  input  logic                     install_way,
  input  dcache_pkg::line_state_t  install_state,
  input  logic                     snoop_update,
  input  dcache_pkg::line_state_t  snoop_state,
  input  logic                     touch,
  output logic                     cpu_hit,
  output logic                     cpu_way,
  output dcache_pkg::line_state_t  cpu_state,
  output logic                     victim_way,
  output dcache_pkg::tag_t         victim_tag,
  output dcache_pkg::line_state_t  victim_state,
  output logic                     snoop_hit,
  output logic                     snoop_way,
  output dcache_pkg::line_state_t  snoop_line_state
);

  // Index sits just above byte and block offsets
  localparam int idx_lsb = 2 + $clog2(words_per_block);
  localparam int tag_msb = $bits(dcache_pkg::word_t) - 1;

  dcache_pkg::tag_t        tags   [num_sets][num_ways];
  dcache_pkg::line_state_t states [num_sets][num_ways];
  // One bit per set, names the way to evict next
  logic [num_sets-1:0]     lru;

  dcache_pkg::index_t cpu_index;
  dcache_pkg::index_t snoop_index;
  dcache_pkg::tag_t   cpu_tag;
  dcache_pkg::tag_t   snoop_tag;

  assign cpu_index   = dmem_addr[idx_lsb +: $bits(dcache_pkg::index_t)];
  assign cpu_tag     = dmem_addr[tag_msb -: $bits(dcache_pkg::tag_t)];
  assign snoop_index = cc_snoop_addr[idx_lsb +: $bits(dcache_pkg::index_t)];
  assign snoop_tag   = cc_snoop_addr[tag_msb -: $bits(dcache_pkg::tag_t)];

  // Compare both addresses against every way of their sets
  always_comb
  begin
    cpu_hit          = 1'b0;
    cpu_way          = 1'b0;
    cpu_state        = dcache_pkg::invalid;
    snoop_hit        = 1'b0;
    snoop_way        = 1'b0;
    snoop_line_state = dcache_pkg::invalid;
    for (int w = 0; w < num_ways; w++)
    begin
      if (states[cpu_index][w] != dcache_pkg::invalid && tags[cpu_index][w] == cpu_tag)
      begin
        cpu_hit   = 1'b1;
        cpu_way   = 1'(w);
        cpu_state = states[cpu_index][w];
      end
      if (states[snoop_index][w] != dcache_pkg::invalid &&
          tags[snoop_index][w] == snoop_tag)
      begin
        snoop_hit        = 1'b1;
        snoop_way        = 1'(w);
        snoop_line_state = states[snoop_index][w];
      end
    end
  end

  // Victim is whatever the LRU bit points at
  assign victim_way   = lru[cpu_index];
  assign victim_tag   = tags[cpu_index][victim_way];
  assign victim_state = states[cpu_index][victim_way];

  // Tag written only when a fill completes
  always_ff @(posedge CLK)
  begin
    if (install)
    begin
      tags[cpu_index][install_way] <= cpu_tag;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      for (int s = 0; s < num_sets; s++)
      begin
        for (int w = 0; w < num_ways; w++)
        begin
          states[s][w] <= dcache_pkg::invalid;
        end
      end
      lru <= '0;
    end
    else
    begin
      if (install)
      begin
        states[cpu_index][install_way] <= install_state;
      end
      // Downgrade or invalidate after a snoop
      if (snoop_update)
      begin
        states[snoop_index][snoop_way] <= snoop_state;
      end
      // Point at the way not just used
      if (touch)
      begin
        lru[cpu_index] <= ~cpu_way;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_controller.sv
/*
  Miss, write-back and snoop sequencer for the data cache.
  Snoops are taken only from idle; d_wait high stalls every bus state.
  A store to a shared line refetches into the same way with cc_write high.
*/
`timescale 1ns/10ps
`default_nettype none

module dcache_controller (
  input  logic                     CLK,
  input  logic                     reset,
  input  logic                     dmem_ren,
  input  logic                     dmem_wen,
  input  logic                     cc_wait,
  input  logic                     cc_inv,
  input  logic                     d_wait,
  input  dcache_pkg::word_t        dmem_addr,
  input  dcache_pkg::word_t        cc_snoop_addr,
  input  logic                     cpu_hit,
  input  logic                     cpu_way,
  input  logic                     victim_way,
  input  logic                     snoop_hit,
  input  logic                     snoop_way,
  input  dcache_pkg::line_state_t  cpu_state,
  input  dcache_pkg::line_state_t  victim_state,
  input  dcache_pkg::line_state_t  snoop_line_state,
  input  dcache_pkg::tag_t         victim_tag,
  output logic                     dhit,
  output logic                     d_ren,
  output logic                     d_wen,
  output logic                     cc_trans,
  output logic                     cc_write,
  output dcache_pkg::word_t        d_addr,
  output logic                     install,
  output logic                     install_way,
  output dcache_pkg::line_state_t  install_state,
  output logic                     snoop_update,
  output dcache_pkg::line_state_t  snoop_state,
  output logic                     touch,
  output logic                     data_we,
  output logic                     data_way,
  output logic                     data_word_sel,
  output logic                     data_src_sel,
  output logic                     read_way,
  output logic                     read_word_sel,
  output dcache_pkg::index_t       read_index
);

  // Field positions taken from the package widths
  localparam int tag_msb = $bits(dcache_pkg::word_t) - 1;
  localparam int idx_lsb = tag_msb + 1 - $bits(dcache_pkg::tag_t) - $bits(dcache_pkg::index_t);

  dcache_pkg::ctrl_state_t state;
  dcache_pkg::ctrl_state_t next_state;
  dcache_pkg::index_t      cpu_index;
  dcache_pkg::index_t      snoop_index;
  dcache_pkg::tag_t        cpu_tag;
  dcache_pkg::tag_t        snoop_tag;
  logic                    fill_way;
  logic                    store_hit;
  logic                    snoop_dirty;

  assign cpu_index   = dmem_addr[idx_lsb +: $bits(dcache_pkg::index_t)];
  assign cpu_tag     = dmem_addr[tag_msb -: $bits(dcache_pkg::tag_t)];
  assign snoop_index = cc_snoop_addr[idx_lsb +: $bits(dcache_pkg::index_t)];
  assign snoop_tag   = cc_snoop_addr[tag_msb -: $bits(dcache_pkg::tag_t)];

  // Shared hit on a store reuses its own way, else the LRU victim
  assign fill_way    = cpu_hit ? cpu_way : victim_way;
  assign store_hit   = dmem_wen && cpu_hit && cpu_state == dcache_pkg::modified;
  assign snoop_dirty = snoop_hit && snoop_line_state == dcache_pkg::modified;

  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      state <= dcache_pkg::idle;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state    = state;
    dhit          = 1'b0;
    d_ren         = 1'b0;
    d_wen         = 1'b0;
    cc_trans      = 1'b0;
    cc_write      = 1'b0;
    d_addr        = dmem_addr;
    install       = 1'b0;
    install_way   = fill_way;
    install_state = dmem_wen ? dcache_pkg::modified : dcache_pkg::shared;
    snoop_update  = 1'b0;
    snoop_state   = cc_inv ? dcache_pkg::invalid : dcache_pkg::shared;
    touch         = 1'b0;
    data_we       = 1'b0;
    data_way      = fill_way;
    data_word_sel = 1'b0;
    data_src_sel  = 1'b0;
    read_way      = cpu_way;
    read_word_sel = 1'b0;
    read_index    = cpu_index;
    case (state)
      dcache_pkg::idle:
      begin
        // Snoop wins over a new CPU request
        if (cc_wait)
        begin
          next_state = dcache_pkg::snoop;
        end
        else if (dmem_ren && cpu_hit)
        begin
          dhit  = 1'b1;
          touch = 1'b1;
        end
        else if (store_hit)
        begin
          dhit          = 1'b1;
          touch         = 1'b1;
          data_we       = 1'b1;
          data_way      = cpu_way;
          data_word_sel = dmem_addr[idx_lsb-1];
          data_src_sel  = 1'b1;
        end
        else if (dmem_ren || dmem_wen)
        begin
          // Dirty victim goes out before the fill
          if (!cpu_hit && victim_state == dcache_pkg::modified)
          begin
            next_state = dcache_pkg::writeback0;
          end
          else
          begin
            next_state = dcache_pkg::fetch0;
          end
        end
      end
      dcache_pkg::writeback0, dcache_pkg::writeback1:
      begin
        cc_trans      = 1'b1;
        d_wen         = 1'b1;
        read_way      = victim_way;
        read_word_sel = (state == dcache_pkg::writeback1);
        d_addr        = {victim_tag, cpu_index, read_word_sel, 2'b00};
        if (!d_wait)
        begin
          if (state == dcache_pkg::writeback0)
          begin
            next_state = dcache_pkg::writeback1;
          end
          else
          begin
            next_state = dcache_pkg::fetch0;
          end
        end
      end
      dcache_pkg::fetch0, dcache_pkg::fetch1:
      begin
        cc_trans      = 1'b1;
        // Exclusive read when the fill serves a store
        cc_write      = dmem_wen;
        d_ren         = 1'b1;
        data_word_sel = (state == dcache_pkg::fetch1);
        d_addr        = {cpu_tag, cpu_index, data_word_sel, 2'b00};
        if (!d_wait)
        begin
          data_we = 1'b1;
          if (state == dcache_pkg::fetch0)
          begin
            next_state = dcache_pkg::fetch1;
          end
          else
          begin
            // Tag and state land with the last word
            install    = 1'b1;
            next_state = dcache_pkg::idle;
          end
        end
      end
      dcache_pkg::snoop:
      begin
        cc_trans   = 1'b1;
        cc_write   = snoop_dirty;
        read_way   = snoop_way;
        read_index = snoop_index;
        d_addr     = {snoop_tag, snoop_index, 1'b0, 2'b00};
        if (snoop_dirty)
        begin
          next_state = dcache_pkg::snoop_flush0;
        end
        else
        begin
          // Clean line only needs the invalidate
          snoop_update = snoop_hit && cc_inv;
          if (!cc_wait)
          begin
            next_state = dcache_pkg::idle;
          end
        end
      end
      dcache_pkg::snoop_flush0, dcache_pkg::snoop_flush1:
      begin
        cc_trans      = 1'b1;
        cc_write      = 1'b1;
        d_wen         = 1'b1;
        read_way      = snoop_way;
        read_index    = snoop_index;
        read_word_sel = (state == dcache_pkg::snoop_flush1);
        d_addr        = {snoop_tag, snoop_index, read_word_sel, 2'b00};
        if (!d_wait)
        begin
          if (state == dcache_pkg::snoop_flush0)
          begin
            next_state = dcache_pkg::snoop_flush1;
          end
          else
          begin
            // Shared, or invalid on cc_inv; then wait for cc_wait to drop
            snoop_update = 1'b1;
            next_state   = dcache_pkg::snoop;
          end
        end
      end
      default:
      begin
        next_state = dcache_pkg::idle;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/dcache_data_array.sv
/*
  Block data storage, indexed by set, way and word.
  Writes always target the set of dmem_addr; no reset on the data.
  dmem_load follows read_way, which the controller holds at the hit way in idle.
*/
`timescale 1ns/10ps
`default_nettype none

module dcache_data_array #(
  parameter int num_sets        = 8,
  parameter int num_ways        = 2,
  parameter int words_per_block = 2
) (
  input  logic                CLK,
  input  dcache_pkg::word_t   dmem_addr,
  input  logic                data_we,
  input  logic                data_way,
  input  logic                data_word_sel,
  input  logic                data_src_sel,
  input  logic                read_way,
  input  logic                read_word_sel,
  input  dcache_pkg::index_t  read_index,
  input  dcache_pkg::word_t   d_load,
  input  dcache_pkg::word_t   dmem_store,
  output dcache_pkg::word_t   dmem_load,
  output dcache_pkg::word_t   d_store
);

  // Block offset right above the byte offset
  localparam int word_lsb = 2;
  localparam int idx_lsb  = word_lsb + $clog2(words_per_block);

  dcache_pkg::word_t  blocks [num_sets][num_ways][words_per_block];
  dcache_pkg::index_t cpu_index;
  logic               cpu_word;

  assign cpu_index = dmem_addr[idx_lsb +: $bits(dcache_pkg::index_t)];
  assign cpu_word  = dmem_addr[word_lsb];

  // Fill word from the bus, or store word from the CPU
  always_ff @(posedge CLK)
  begin
    if (data_we)
    begin
      if (data_src_sel)
      begin
        blocks[cpu_index][data_way][data_word_sel] <= dmem_store;
      end
      else
      begin
        blocks[cpu_index][data_way][data_word_sel] <= d_load;
      end
    end
  end

  // Load word of the hit way
  assign dmem_load = blocks[cpu_index][read_way][cpu_word];

  // Write-back word, victim or snooped line
  assign d_store = blocks[read_index][read_way][read_word_sel];

endmodule

`default_nettype wire

//--- design/dcache.sv
/*
  Two-way, eight-set MSI data cache with two-word blocks.
  Requests are plain levels held until dhit or until d_wait drops.
  Geometry parameters must match the field widths in dcache_pkg.
*/
`timescale 1ns/10ps
`default_nettype none

module dcache #(
  parameter int num_sets        = 8,
  parameter int num_ways        = 2,
  parameter int words_per_block = 2
) (
  input  logic               CLK,
  input  logic               reset,
  // CPU side
  input  logic               dmem_ren,
  input  logic               dmem_wen,
  input  dcache_pkg::word_t  dmem_addr,
  input  dcache_pkg::word_t  dmem_store,
  output logic               dhit,
  output dcache_pkg::word_t  dmem_load,
  // Memory bus
  input  logic               d_wait,
  input  dcache_pkg::word_t  d_load,
  output logic               d_ren,
  output logic               d_wen,
  output dcache_pkg::word_t  d_addr,
  output dcache_pkg::word_t  d_store,
  // Coherence controller
  input  logic               cc_wait,
  input  logic               cc_inv,
  input  dcache_pkg::word_t  cc_snoop_addr,
  output logic               cc_trans,
  output logic               cc_write
);

  // Lookup to controller
  logic                    cpu_hit;
  logic                    cpu_way;
  dcache_pkg::line_state_t cpu_state;
  logic                    victim_way;
  dcache_pkg::tag_t        victim_tag;
  dcache_pkg::line_state_t victim_state;
  logic                    snoop_hit;
  logic                    snoop_way;
  dcache_pkg::line_state_t snoop_line_state;

  // Controller to lookup
  logic                    install;
  logic                    install_way;
  dcache_pkg::line_state_t install_state;
  logic                    snoop_update;
  dcache_pkg::line_state_t snoop_state;
  logic                    touch;

  // Controller to data array
  logic                    data_we;
  logic                    data_way;
  logic                    data_word_sel;
  logic                    data_src_sel;
  logic                    read_way;
  logic                    read_word_sel;
  dcache_pkg::index_t      read_index;

  dcache_lookup #(
    .num_sets(num_sets),
    .num_ways(num_ways),
    .words_per_block(words_per_block)
  ) uut_lookup (
    .CLK(CLK), .reset(reset), .dmem_addr(dmem_addr), .cc_snoop_addr(cc_snoop_addr),
    .install(install), .install_way(install_way), .install_state(install_state),
    .snoop_update(snoop_update), .snoop_state(snoop_state), .touch(touch),
    .cpu_hit(cpu_hit), .cpu_way(cpu_way), .cpu_state(cpu_state),
    .victim_way(victim_way), .victim_tag(victim_tag), .victim_state(victim_state),
    .snoop_hit(snoop_hit), .snoop_way(snoop_way), .snoop_line_state(snoop_line_state)
  );

  dcache_controller uut_controller (
    .CLK(CLK), .reset(reset), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .cc_wait(cc_wait), .cc_inv(cc_inv), .d_wait(d_wait),
    .dmem_addr(dmem_addr), .cc_snoop_addr(cc_snoop_addr),
    .cpu_hit(cpu_hit), .cpu_way(cpu_way), .victim_way(victim_way),
    .snoop_hit(snoop_hit), .snoop_way(snoop_way), .cpu_state(cpu_state),
    .victim_state(victim_state), .snoop_line_state(snoop_line_state),
    .victim_tag(victim_tag), .dhit(dhit), .d_ren(d_ren), .d_wen(d_wen),
    .cc_trans(cc_trans), .cc_write(cc_write), .d_addr(d_addr),
    .install(install), .install_way(install_way), .install_state(install_state),
    .snoop_update(snoop_update), .snoop_state(snoop_state), .touch(touch),
    .data_we(data_we), .data_way(data_way), .data_word_sel(data_word_sel),
    .data_src_sel(data_src_sel), .read_way(read_way),
    .read_word_sel(read_word_sel), .read_index(read_index)
  );

  dcache_data_array #(
    .num_sets(num_sets),
    .num_ways(num_ways),
    .words_per_block(words_per_block)
  ) uut_data (
    .CLK(CLK), .dmem_addr(dmem_addr), .data_we(data_we), .data_way(data_way),
    .data_word_sel(data_word_sel), .data_src_sel(data_src_sel),
    .read_way(read_way), .read_word_sel(read_word_sel), .read_index(read_index),
    .d_load(d_load), .dmem_store(dmem_store), .dmem_load(dmem_load), .d_store(d_store)
  );

endmodule

`default_nettype wire

//--- verification/dcache_tb_clock.sv
/*
  Free-running testbench clock, 40 ns period, starts low.
*/
`timescale 1ns/10ps
`default_nettype none

module dcache_tb_clock (
  output logic clk
);

  // Half of the 40 ns period
  localparam int half_period = 20;

  initial
  begin
    clk = 1'b0;
    forever
      #(half_period) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
/*
  Random loads, stores and snoops against a reference model of the cache.
  The testbench plays memory bus and coherence controller; one request at a time.
  Memory only changes through this cache, so no other core writes are modeled.
*/
`timescale 1ns/10ps
`default_nettype none

module dcache_tb;

  localparam int num_ops      = 400;
  localparam int max_delay    = 3;
  localparam int clk_period   = 40;
  // Four bus words at the longest wait, plus slack
  localparam int worst_cycles = 40;

  logic               clk;
  logic               reset;
  logic               dmem_ren;
  logic               dmem_wen;
  dcache_pkg::word_t  dmem_addr;
  dcache_pkg::word_t  dmem_store;
  logic               dhit;
  dcache_pkg::word_t  dmem_load;
  logic               d_wait;
  dcache_pkg::word_t  d_load;
  logic               d_ren;
  logic               d_wen;
  dcache_pkg::word_t  d_addr;
  dcache_pkg::word_t  d_store;
  logic               cc_wait;
  logic               cc_inv;
  dcache_pkg::word_t  cc_snoop_addr;
  logic               cc_trans;
  logic               cc_write;

  int errors;

  // Memory behind the bus, and architectural values seen by the CPU
  dcache_pkg::word_t bus_mem   [dcache_pkg::word_t];
  dcache_pkg::word_t model_mem [dcache_pkg::word_t];

  // Bus words completed during the current operation
  dcache_pkg::word_t bus_addr_q [$];
  dcache_pkg::word_t bus_data_q [$];
  logic              bus_wr_q   [$];
  logic              bus_ccw_q  [$];

  // Model copies of tags, MSI states and LRU bits
  dcache_pkg::tag_t        m_tag   [8][2];
  dcache_pkg::line_state_t m_state [8][2];
  logic                    m_lru   [8];

  dcache_tb_clock clock_gen (.clk(clk));

  dcache uut (
    .CLK(clk), .reset(reset), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dhit(dhit), .dmem_load(dmem_load),
    .d_wait(d_wait), .d_load(d_load), .d_ren(d_ren), .d_wen(d_wen), .d_addr(d_addr),
    .d_store(d_store), .cc_wait(cc_wait), .cc_inv(cc_inv), .cc_snoop_addr(cc_snoop_addr),
    .cc_trans(cc_trans), .cc_write(cc_write)
  );

  // Power-on memory contents, distinct for every address
  function automatic dcache_pkg::word_t fill_pattern(input dcache_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic dcache_pkg::word_t model_read(input dcache_pkg::word_t addr);
    if (model_mem.exists(addr))
      return model_mem[addr];
    return fill_pattern(addr);
  endfunction

  function automatic dcache_pkg::word_t bus_read(input dcache_pkg::word_t addr);
    if (bus_mem.exists(addr))
      return bus_mem[addr];
    return fill_pattern(addr);
  endfunction

  // Few tags over four sets, so ways conflict often
  function automatic dcache_pkg::word_t pick_addr();
    dcache_pkg::tag_t   tag;
    dcache_pkg::index_t set;
    tag = dcache_pkg::tag_t'(26'h0_0400 + $urandom_range(3));
    set = dcache_pkg::index_t'($urandom_range(3));
    return {tag, set, 1'($urandom_range(1)), 2'b00};
  endfunction

  task automatic check_load(input dcache_pkg::word_t addr, input dcache_pkg::word_t got,
                            input dcache_pkg::word_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: load %h returned %h, expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic check_writeback(input logic got_wr, input dcache_pkg::word_t got_addr,
                                 input dcache_pkg::word_t got_data,
                                 input dcache_pkg::word_t exp_addr,
                                 input dcache_pkg::word_t exp_data);
    if (!got_wr || got_addr !== exp_addr || got_data !== exp_data)
    begin
      errors++;
      $display("Mismatch at %0t: write-back wr=%b %h:%h, expected %h:%h",
               $time, got_wr, got_addr, got_data, exp_addr, exp_data);
    end
  endtask

  task automatic check_fetch(input logic got_wr, input dcache_pkg::word_t got_addr,
                             input logic got_ccw, input dcache_pkg::word_t exp_addr,
                             input logic exp_ccw);
    if (got_wr || got_addr !== exp_addr || got_ccw !== exp_ccw)
    begin
      errors++;
      $display("Mismatch at %0t: fetch wr=%b %h cc_write=%b, expected %h cc_write=%b",
               $time, got_wr, got_addr, got_ccw, exp_addr, exp_ccw);
    end
  endtask

  // Expected flags follow from the model's line state
  task automatic check_snoop(input logic got_trans, input logic got_write,
                             input dcache_pkg::line_state_t line);
    if (got_trans !== 1'b1 || got_write !== (line == dcache_pkg::modified))
    begin
      errors++;
      $display("Mismatch at %0t: snoop cc_trans=%b cc_write=%b for line state %s",
               $time, got_trans, got_write, line.name());
    end
  endtask

  task automatic clear_bus_log();
    bus_addr_q.delete();
    bus_data_q.delete();
    bus_wr_q.delete();
    bus_ccw_q.delete();
  endtask

  task automatic run_op(input logic wr, input dcache_pkg::word_t addr);
    dcache_pkg::index_t set;
    dcache_pkg::tag_t   tag;
    dcache_pkg::word_t  data;
    dcache_pkg::word_t  got;
    dcache_pkg::word_t  vict_base;
    dcache_pkg::word_t  blk_base;
    logic               hit;
    logic               miss;
    logic               way;
    logic               dirty;
    int                 exp_words;
    set      = addr[5:3];
    tag      = addr[31:6];
    data     = $urandom;
    blk_base = {tag, set, 3'b000};
    hit      = 1'b0;
    way      = m_lru[set];
    for (int w = 0; w < 2; w++)
    begin
      if (m_state[set][w] != dcache_pkg::invalid && m_tag[set][w] == tag)
      begin
        hit = 1'b1;
        way = 1'(w);
      end
    end
    // Store to a shared line refetches exclusive into the same way
    miss      = !hit || (wr && m_state[set][way] != dcache_pkg::modified);
    dirty     = !hit && m_state[set][way] == dcache_pkg::modified;
    vict_base = {m_tag[set][way], set, 3'b000};
    exp_words = miss ? (dirty ? 4 : 2) : 0;
    clear_bus_log();
    @(posedge clk);
    dmem_ren   <= !wr;
    dmem_wen   <= wr;
    dmem_addr  <= addr;
    dmem_store <= data;
    @(negedge clk);
    // A hit answers in the cycle the request appears
    if (!miss && !dhit)
    begin
      errors++;
      $display("Mismatch at %0t: dhit low on a hit to %h", $time, addr);
    end
    while (!dhit)
      @(negedge clk);
    got = dmem_load;
    @(posedge clk);
    dmem_ren <= 1'b0;
    dmem_wen <= 1'b0;
    if (bus_addr_q.size() != exp_words)
    begin
      errors++;
      $display("Error at %0t: access to %h made %0d bus words instead of %0d",
               $time, addr, bus_addr_q.size(), exp_words);
    end
    else
    begin
      for (int i = 0; i < exp_words; i++)
      begin
        if (dirty && i < 2)
          check_writeback(bus_wr_q[i], bus_addr_q[i], bus_data_q[i],
                          vict_base + 32'(4 * i), model_read(vict_base + 32'(4 * i)));
        else
          check_fetch(bus_wr_q[i], bus_addr_q[i], bus_ccw_q[i],
                      blk_base + 32'(4 * (dirty ? i - 2 : i)), wr);
      end
    end
    if (!wr)
      check_load(addr, got, model_read(addr));
    else
      model_mem[addr] = data;
    if (miss)
    begin
      m_tag[set][way]   = tag;
      m_state[set][way] = wr ? dcache_pkg::modified : dcache_pkg::shared;
    end
    m_lru[set] = !way;
  endtask

  task automatic run_snoop(input dcache_pkg::word_t addr, input logic inv);
    dcache_pkg::index_t      set;
    dcache_pkg::tag_t        tag;
    dcache_pkg::word_t       base;
    dcache_pkg::line_state_t line;
    int                      way;
    int                      exp_words;
    set  = addr[5:3];
    tag  = addr[31:6];
    base = {tag, set, 3'b000};
    line = dcache_pkg::invalid;
    way  = 0;
    for (int w = 0; w < 2; w++)
    begin
      if (m_state[set][w] != dcache_pkg::invalid && m_tag[set][w] == tag)
      begin
        line = m_state[set][w];
        way  = w;
      end
    end
    exp_words = (line == dcache_pkg::modified) ? 2 : 0;
    clear_bus_log();
    @(posedge clk);
    cc_wait       <= 1'b1;
    cc_snoop_addr <= addr;
    cc_inv        <= inv;
    // Idle cache enters the snoop state one cycle after cc_wait
    repeat (2) @(negedge clk);
    check_snoop(cc_trans, cc_write, line);
    // Flush runs until the line is no longer dirty
    while (d_wen || cc_write)
      @(negedge clk);
    @(posedge clk);
    cc_wait <= 1'b0;
    if (bus_addr_q.size() != exp_words)
    begin
      errors++;
      $display("Error at %0t: snoop of %h made %0d bus words instead of %0d",
               $time, addr, bus_addr_q.size(), exp_words);
    end
    else
    begin
      for (int i = 0; i < exp_words; i++)
        check_writeback(bus_wr_q[i], bus_addr_q[i], bus_data_q[i],
                        base + 32'(4 * i), model_read(base + 32'(4 * i)));
    end
    if (line == dcache_pkg::modified)
      m_state[set][way] = inv ? dcache_pkg::invalid : dcache_pkg::shared;
    else if (line == dcache_pkg::shared && inv)
      m_state[set][way] = dcache_pkg::invalid;
  endtask

  // Bus responder, one word per cycle of d_wait low after a random wait
  initial
  begin : bus_responder
    int                delay;
    logic              next_wait;
    dcache_pkg::word_t next_load;
    d_wait = 1'b1;
    d_load = '0;
    delay  = 0;
    forever
    begin
      @(negedge clk);
      next_wait = 1'b1;
      next_load = d_load;
      if ((d_ren || d_wen) && !d_wait)
      begin
        // Word completes at the coming edge
        bus_addr_q.push_back(d_addr);
        bus_data_q.push_back(d_wen ? d_store : d_load);
        bus_wr_q.push_back(d_wen);
        bus_ccw_q.push_back(cc_write);
        if (d_wen)
          bus_mem[d_addr] = d_store;
      end
      else if (d_ren || d_wen)
      begin
        if (delay > 0)
          delay--;
        else
        begin
          next_wait = 1'b0;
          next_load = bus_read(d_addr);
          delay     = $urandom_range(max_delay);
        end
      end
      @(posedge clk);
      d_wait <= next_wait;
      d_load <= next_load;
    end
  end

  initial
  begin : main_sequence
    dcache_pkg::word_t addr;
    void'($urandom(53171));
    errors        = 0;
    reset         = 1'b1;
    dmem_ren      = 1'b0;
    dmem_wen      = 1'b0;
    dmem_addr     = '0;
    dmem_store    = '0;
    cc_wait       = 1'b0;
    cc_inv        = 1'b0;
    cc_snoop_addr = '0;
    for (int s = 0; s < 8; s++)
    begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
        m_tag[s][w]   = '0;
        m_state[s][w] = dcache_pkg::invalid;
      end
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // Three tags through set 7, dirty first one evicted then reread
    for (int k = 0; k < 4; k++)
      run_op(k == 0, {dcache_pkg::tag_t'(26'h0_0800 + k % 3), 3'd7, 3'b000});
    for (int n = 0; n < num_ops; n++)
    begin
      addr = pick_addr();
      if ($urandom_range(5) == 0)
        run_snoop(addr, 1'($urandom_range(1)));
      else
        run_op(1'($urandom_range(1)), addr);
    end
    repeat (2) @(posedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Bound on run length, every operation at its worst case
  initial
  begin : watchdog
    #((num_ops + 10) * worst_cycles * clk_period);
    $display("Timeout: the cache stopped answering requests before the run ended");
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/dcache_pkg.sv
design/dcache_lookup.sv
design/dcache_controller.sv
design/dcache_data_array.sv
design/dcache.sv
verification/dcache_tb_clock.sv
verification/dcache_tb.sv

//--- Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
EXTRA     ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
